/* run.sh */
#!/bin/sh
# Build and run the fetch frontend testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal \
   --top-module tb_fetch_frontend \
   -f verilog.f \
   -o tb_fetch_frontend &&
./obj_dir/tb_fetch_frontend ||
{ echo "Simulation run reported a failure"; exit 1; }

/* verification/tb_fetch_frontend.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the fetch frontend
// Clock, reset, four-phase memory responder,
// BTB and PC stream reference model,
// stimulus table and compare tasks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "frontend_config.svh"

module tb_fetch_frontend;

   localparam int NUM_ROWS = 8;
   localparam int POP_ALL = 0;
   localparam int POP_RAND = 1;
   localparam int POP_BURSTY = 2;

   typedef struct packed
   {
      logic             do_flush;
      fetch_pkg::pc_t   tgt;
      logic             do_wb;
      logic             wb_taken;
      fetch_pkg::pc_t   wb_pc;
      fetch_pkg::pc_t   wb_tgt;
      logic [1:0]       pol;
      logic [7:0]       cnt;
   } row_t;

   logic                            clk;
   logic                            rst_n;
   logic                            flush;
   fetch_pkg::pc_t                  flush_tgt;
   logic                            imem_req;
   fetch_pkg::win_addr_t            imem_addr;
   logic                            imem_ack;
   logic [`FE_FW*`FE_INSN_DW-1:0]   imem_rdata;
   fetch_pkg::slot_mask_t           id_valid;
   fetch_pkg::insn_t                id_ins [`FE_FW];
   fetch_pkg::pc_t                  id_pc [`FE_FW];
   fetch_pkg::slot_mask_t           id_bpu_taken;
   fetch_pkg::slot_cnt_t            id_pop_cnt;
   logic                            bpu_wb;
   logic                            bpu_wb_taken;
   fetch_pkg::pc_t                  bpu_wb_pc;
   fetch_pkg::pc_t                  bpu_wb_npc_act;

   row_t                rows [NUM_ROWS];
   // Reference model state
   fetch_pkg::pc_t      mdl_pc;
   logic                mdl_vld [`FE_BTB_NUM];
   fetch_pkg::pc_t      mdl_tag [`FE_BTB_NUM];
   fetch_pkg::pc_t      mdl_tgt [`FE_BTB_NUM];
   int                  mdl_cnt [`FE_BTB_NUM];
   fetch_pkg::pc_t      exp_pc [$];
   logic                exp_tkn [$];
   int                  stall_left;
   // Protocol monitor state
   logic                prev_req;
   logic                prev_ack;
   fetch_pkg::win_addr_t prev_addr;
   int                  req_starts;

   fetch_frontend i_dut
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .flush            (flush),
      .flush_tgt        (flush_tgt),
      .imem_req         (imem_req),
      .imem_addr        (imem_addr),
      .imem_ack         (imem_ack),
      .imem_rdata       (imem_rdata),
      .id_valid         (id_valid),
      .id_ins           (id_ins),
      .id_pc            (id_pc),
      .id_bpu_taken     (id_bpu_taken),
      .id_pop_cnt       (id_pop_cnt),
      .bpu_wb           (bpu_wb),
      .bpu_wb_taken     (bpu_wb_taken),
      .bpu_wb_pc        (bpu_wb_pc),
      .bpu_wb_npc_act   (bpu_wb_npc_act)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_with_failure();
      $display("Test failed");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_pc(input string name, input fetch_pkg::pc_t act,
                           input fetch_pkg::pc_t exp);
      if (act !== exp)
      begin
         $display("Error: %s is %h, expected %h", name, act, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_insn(input string name, input fetch_pkg::insn_t act,
                             input fetch_pkg::insn_t exp);
      if (act !== exp)
      begin
         $display("Error: %s is %h, expected %h", name, act, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_taken(input string name, input fetch_pkg::slot_cnt_t act,
                              input fetch_pkg::slot_cnt_t exp);
      if (act !== exp)
      begin
         $display("Error: %s is %h, expected %h", name, act, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_mask(input string name, input fetch_pkg::slot_mask_t act,
                             input fetch_pkg::slot_mask_t exp);
      if (act !== exp)
      begin
         $display("Error: %s is %h, expected %h", name, act, exp);
         stop_with_failure();
      end
   endtask

   // Memory content, word address XOR a fixed pattern
   function automatic fetch_pkg::insn_t mem_word(input fetch_pkg::pc_t w);
      return fetch_pkg::insn_t'(w) ^ 32'h5a5a0000;
   endfunction

   function automatic logic predict(input fetch_pkg::pc_t p);
      int idx;
      idx = int'(p % `FE_BTB_NUM);
      return mdl_vld[idx] && (mdl_tag[idx] == p / `FE_BTB_NUM) && (mdl_cnt[idx] >= 2);
   endfunction

   function automatic void model_train(input fetch_pkg::pc_t p, input logic tkn,
                                       input fetch_pkg::pc_t tgt);
      int idx;
      logic hit;
      idx = int'(p % `FE_BTB_NUM);
      hit = mdl_vld[idx] && (mdl_tag[idx] == p / `FE_BTB_NUM);
      if (tkn)
      begin
         mdl_cnt[idx] = hit ? ((mdl_cnt[idx] < 3) ? mdl_cnt[idx] + 1 : 3) : 2;
         mdl_vld[idx] = 1'b1;
         mdl_tag[idx] = p / `FE_BTB_NUM;
         mdl_tgt[idx] = tgt;
      end
      else if (hit && mdl_cnt[idx] > 0)
         mdl_cnt[idx] = mdl_cnt[idx] - 1;
   endfunction

   // Expected instructions of one fetch window
   function automatic void model_window();
      int first;
      logic done;
      fetch_pkg::pc_t win;
      fetch_pkg::pc_t p;
      first = int'(mdl_pc % `FE_FW);
      win = mdl_pc - fetch_pkg::pc_t'(first);
      done = 1'b0;
      for (int i = first; i < `FE_FW; i++)
      begin
         p = win + fetch_pkg::pc_t'(i);
         if (!done)
         begin
            exp_pc.push_back(p);
            exp_tkn.push_back(predict(p));
            if (predict(p))
            begin
               mdl_pc = mdl_tgt[int'(p % `FE_BTB_NUM)];
               done = 1'b1;
            end
         end
      end
      if (!done)
         mdl_pc = win + fetch_pkg::pc_t'(`FE_FW);
   endfunction

   function automatic void model_flush(input fetch_pkg::pc_t tgt);
      mdl_pc = tgt;
      exp_pc.delete();
      exp_tkn.delete();
   endfunction

   function automatic int pick_pop(input int nv, input int pol);
      if (pol == POP_ALL)
         return nv;
      if (pol == POP_BURSTY)
      begin
         if (stall_left > 0)
         begin
            stall_left = stall_left - 1;
            return 0;
         end
         // Long decode stall, long enough to fill the queue
         if ($urandom % 8 == 0)
         begin
            stall_left = 120;
            return 0;
         end
      end
      return int'($urandom % (nv + 1));
   endfunction

   task automatic observe(input int total, input int pol);
      int got;
      int idle;
      int nv;
      int p;
      fetch_pkg::pc_t e_pc;
      logic e_tkn;
      got = 0;
      idle = 0;
      while (got < total)
      begin
         @(negedge clk);
         flush = 1'b0;
         bpu_wb = 1'b0;
         nv = $countones(id_valid);
         idle = (nv == 0) ? idle + 1 : 0;
         if (idle > 200)
         begin
            $display("Decode received no instruction for 200 cycles");
            stop_with_failure();
         end
         p = pick_pop(nv, pol);
         if (p > total - got)
            p = total - got;
         for (int i = 0; i < p; i++)
         begin
            while (exp_pc.size() == 0)
               model_window();
            e_pc = exp_pc.pop_front();
            e_tkn = exp_tkn.pop_front();
            check_pc($sformatf("id_pc[%0d]", i), id_pc[i], e_pc);
            check_insn($sformatf("id_ins[%0d]", i), id_ins[i], mem_word(e_pc));
            check_taken($sformatf("id_bpu_taken[%0d]", i),
                        fetch_pkg::slot_cnt_t'(id_bpu_taken[i]),
                        fetch_pkg::slot_cnt_t'(e_tkn));
         end
         id_pop_cnt = fetch_pkg::slot_cnt_t'(p);
         got = got + p;
      end
   endtask

   // Four-phase memory responder
   initial
   begin : mem_responder
      int delay;
      int guard;
      fetch_pkg::pc_t w;
      imem_ack = 1'b0;
      imem_rdata = '0;
      forever
      begin
         guard = 0;
         while (imem_req !== 1'b1)
         begin
            @(negedge clk);
            guard = guard + 1;
            if (guard > 2000)
            begin
               $display("No memory request arrived for 2000 cycles");
               stop_with_failure();
            end
         end
         delay = 1 + int'($urandom % 4);
         repeat (delay) @(negedge clk);
         w = fetch_pkg::pc_t'(imem_addr >> `FE_P_INSN_LEN);
         imem_rdata = {mem_word(w + 1), mem_word(w)};
         imem_ack = 1'b1;
         guard = 0;
         while (imem_req !== 1'b0)
         begin
            @(negedge clk);
            guard = guard + 1;
            if (guard > 50)
            begin
               $display("Memory request was not released after the ack");
               stop_with_failure();
            end
         end
         delay = 1 + int'($urandom % 4);
         repeat (delay) @(negedge clk);
         imem_ack = 1'b0;
      end
   end

   // Handshake rules and back-pressure, sampled before the edge updates
   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         prev_req = 1'b0;
         prev_ack = 1'b0;
         prev_addr = '0;
         req_starts = 0;
      end
      else
      begin
         if (prev_req && imem_req && (imem_addr !== prev_addr))
         begin
            $display("Error: imem_addr changed from %h to %h during a request",
                     prev_addr, imem_addr);
            stop_with_failure();
         end
         if (!prev_req && imem_req)
         begin
            if (imem_ack || prev_ack)
            begin
               $display("A memory request started while the ack was still high");
               stop_with_failure();
            end
            req_starts = req_starts + 1;
         end
         // Each fetch adds at least one entry, so a full queue stops requests
         if (req_starts > `FE_IQ_DEPTH - 1)
         begin
            $display("Memory request started while the prefetch queue was full");
            stop_with_failure();
         end
         if (flush || id_pop_cnt != '0)
            req_starts = 0;
         prev_req = imem_req;
         prev_ack = imem_ack;
         prev_addr = imem_addr;
      end
   end

   initial
   begin
      void'($urandom(32'ha7b1));
      rst_n = 1'b0;
      flush = 1'b0;
      flush_tgt = '0;
      id_pop_cnt = '0;
      bpu_wb = 1'b0;
      bpu_wb_taken = 1'b0;
      bpu_wb_pc = '0;
      bpu_wb_npc_act = '0;
      stall_left = 0;
      for (int i = 0; i < `FE_BTB_NUM; i++)
      begin
         mdl_vld[i] = 1'b0;
         mdl_tag[i] = '0;
         mdl_tgt[i] = '0;
         mdl_cnt[i] = 0;
      end
      model_flush(fetch_pkg::pc_t'(`FE_RST_VECTOR >> `FE_P_INSN_LEN));
      //          flush tgt        wb    taken wb_pc     wb_tgt    pol   count
      rows[0] = '{1'b0, 30'h00, 1'b0, 1'b0, 30'h00, 30'h00, 2'd0, 8'd12};
      rows[1] = '{1'b1, 30'h81, 1'b0, 1'b0, 30'h00, 30'h00, 2'd0, 8'd6};
      // Loop closed by slot 1, then a slot 0 branch to an odd target
      rows[2] = '{1'b1, 30'h90, 1'b1, 1'b1, 30'h93, 30'h90, 2'd1, 8'd14};
      rows[3] = '{1'b1, 30'ha0, 1'b1, 1'b1, 30'ha2, 30'hb5, 2'd1, 8'd8};
      rows[4] = '{1'b1, 30'ha0, 1'b1, 1'b0, 30'ha2, 30'h00, 2'd0, 8'd8};
      rows[5] = '{1'b1, 30'h90, 1'b0, 1'b0, 30'h00, 30'h00, 2'd2, 8'd40};
      rows[6] = '{1'b0, 30'h00, 1'b0, 1'b0, 30'h00, 30'h00, 2'd1, 8'd20};
      rows[7] = '{1'b1, 30'h1f, 1'b1, 1'b1, 30'h1f, 30'h40, 2'd2, 8'd12};
      repeat (3) @(posedge clk);
      @(negedge clk);
      // Idle frontend while in reset
      check_mask("id_valid", id_valid, '0);
      if (imem_req !== 1'b0)
      begin
         $display("Error: imem_req is %h during reset, expected 0", imem_req);
         stop_with_failure();
      end
      rst_n = 1'b1;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         if (rows[r].do_flush)
         begin
            @(negedge clk);
            flush = 1'b1;
            flush_tgt = rows[r].tgt;
            id_pop_cnt = '0;
            bpu_wb = rows[r].do_wb;
            bpu_wb_taken = rows[r].wb_taken;
            bpu_wb_pc = rows[r].wb_pc;
            bpu_wb_npc_act = rows[r].wb_tgt;
            model_flush(rows[r].tgt);
            if (rows[r].do_wb)
               model_train(rows[r].wb_pc, rows[r].wb_taken, rows[r].wb_tgt);
            @(negedge clk);
            flush = 1'b0;
            bpu_wb = 1'b0;
            // Queue empty one cycle after the flush
            check_mask("id_valid", id_valid, '0);
         end
         observe(int'(rows[r].cnt), int'(rows[r].pol));
      end
      @(negedge clk);
      id_pop_cnt = '0;
      $display("Test passed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_ifs.sv
verilog/pc_gen.sv
verilog/branch_predictor.sv
verilog/imem_fetch.sv
verilog/fetch_queue.sv
verilog/fetch_frontend.sv
verification/tb_fetch_frontend.sv

/* verilog/branch_predictor.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped branch target buffer
// Per-slot lookup, 2-bit saturating counters,
// training from execute writeback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "frontend_config.svh"

module branch_predictor
(
   input  logic                     clk,
   input  logic                     rst_n,
   bpu_lookup_if.responder          lookup,
   input  logic                     bpu_wb,
   input  logic                     bpu_wb_taken,
   input  fetch_pkg::pc_t           bpu_wb_pc,
   input  fetch_pkg::pc_t           bpu_wb_npc_act
);

   logic [`FE_BTB_NUM-1:0]    btb_vld;
   fetch_pkg::btb_tag_t       btb_tag [`FE_BTB_NUM];
   fetch_pkg::pc_t            btb_tgt [`FE_BTB_NUM];
   fetch_pkg::bp_cnt_t        btb_cnt [`FE_BTB_NUM];

   fetch_pkg::btb_idx_t       wb_idx;
   fetch_pkg::bp_cnt_t        wb_cnt;
   logic                      wb_hit;

   function automatic fetch_pkg::btb_idx_t idx_of(input fetch_pkg::pc_t pc);
      return pc[`FE_P_BTB-1:0];
   endfunction

   function automatic fetch_pkg::btb_tag_t tag_of(input fetch_pkg::pc_t pc);
      return pc[`FE_PC_W-1:`FE_P_BTB];
   endfunction

   // Lookup, taken needs a hit and a counter of 2 or 3
   always_comb
   begin
      for (int i = 0; i < `FE_FW; i++)
      begin
         lookup.taken[i]  = btb_vld[idx_of(lookup.slot_pc[i])]
                          & (btb_tag[idx_of(lookup.slot_pc[i])] == tag_of(lookup.slot_pc[i]))
                          & btb_cnt[idx_of(lookup.slot_pc[i])][1];
         lookup.target[i] = btb_tgt[idx_of(lookup.slot_pc[i])];
      end
   end

   assign lookup.any_taken = |lookup.taken;

   // Writeback re-reads its own entry
   assign wb_idx = idx_of(bpu_wb_pc);
   assign wb_cnt = btb_cnt[wb_idx];
   assign wb_hit = btb_vld[wb_idx] & (btb_tag[wb_idx] == tag_of(bpu_wb_pc));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         btb_vld <= '0;
      else if (bpu_wb && bpu_wb_taken)
         btb_vld[wb_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (bpu_wb)
      begin
         if (bpu_wb_taken)
         begin
            btb_tag[wb_idx] <= tag_of(bpu_wb_pc);
            btb_tgt[wb_idx] <= bpu_wb_npc_act;
            // New entries start weakly taken
            if (!wb_hit)
               btb_cnt[wb_idx] <= 2'd2;
            else if (wb_cnt != 2'd3)
               btb_cnt[wb_idx] <= wb_cnt + 2'd1;
         end
         else if (wb_hit && (wb_cnt != 2'd0))
            btb_cnt[wb_idx] <= wb_cnt - 2'd1;
      end
   end

   // Execute trains only with a resolved branch
   a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb |-> !$isunknown({bpu_wb_taken, bpu_wb_pc, bpu_wb_npc_act}));

endmodule

/* verilog/fetch_frontend.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction fetch frontend top level
// PC generator, BTB, memory master, queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "frontend_config.svh"

module fetch_frontend
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           flush,
   input  logic [`FE_PC_W-1:0]            flush_tgt,
   // Instruction memory
   output logic                           imem_req,
   output logic [`FE_AW-1:0]              imem_addr,
   input  logic                           imem_ack,
   input  logic [`FE_FW*`FE_INSN_DW-1:0]  imem_rdata,
   // To decode
   output logic [`FE_FW-1:0]              id_valid,
   output logic [`FE_INSN_DW-1:0]         id_ins [`FE_FW],
   output logic [`FE_PC_W-1:0]            id_pc [`FE_FW],
   output logic [`FE_FW-1:0]              id_bpu_taken,
   input  logic [`FE_P_FW:0]              id_pop_cnt,
   // From execute
   input  logic                           bpu_wb,
   input  logic                           bpu_wb_taken,
   input  logic [`FE_PC_W-1:0]            bpu_wb_pc,
   input  logic [`FE_PC_W-1:0]            bpu_wb_npc_act
);

   logic [`FE_AW-1:0]      fetch_addr;
   logic [`FE_FW-1:0]      slot_valid;
   logic [`FE_PC_W-1:0]    slot_pc [`FE_FW];
   logic [`FE_P_FW:0]      push_cnt;
   logic [`FE_P_FW:0]      push_offset;
   logic                   fetch_done;

   bpu_lookup_if  bpu_if ();
   fetch_pkt_if   pkt_if ();

   pc_gen i_pc_gen
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .flush_tgt     (flush_tgt),
      .fetch_done    (fetch_done),
      .bpu           (bpu_if.requester),
      .fetch_addr    (fetch_addr),
      .slot_valid    (slot_valid),
      .slot_pc       (slot_pc),
      .push_cnt      (push_cnt),
      .push_offset   (push_offset)
   );

   branch_predictor i_bpu
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .lookup           (bpu_if.responder),
      .bpu_wb           (bpu_wb),
      .bpu_wb_taken     (bpu_wb_taken),
      .bpu_wb_pc        (bpu_wb_pc),
      .bpu_wb_npc_act   (bpu_wb_npc_act)
   );

   imem_fetch i_imem_fetch
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .fetch_addr    (fetch_addr),
      .slot_valid    (slot_valid),
      .slot_pc       (slot_pc),
      .push_cnt      (push_cnt),
      .push_offset   (push_offset),
      .bpu_taken     (bpu_if.taken),
      .imem_req      (imem_req),
      .imem_addr     (imem_addr),
      .imem_ack      (imem_ack),
      .imem_rdata    (imem_rdata),
      .fetch_done    (fetch_done),
      .pkt           (pkt_if.producer)
   );

   fetch_queue i_fetch_queue
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .pkt           (pkt_if.consumer),
      .id_valid      (id_valid),
      .id_ins        (id_ins),
      .id_pc         (id_pc),
      .id_bpu_taken  (id_bpu_taken),
      .id_pop_cnt    (id_pop_cnt)
   );

endmodule

/* verilog/fetch_ifs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frontend internal interfaces
// bpu_lookup_if  per-slot BTB lookup
// fetch_pkt_if   fetch packet toward the queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "frontend_config.svh"

interface bpu_lookup_if;
   fetch_pkg::pc_t         slot_pc [`FE_FW];
   fetch_pkg::slot_mask_t  taken;
   fetch_pkg::pc_t         target [`FE_FW];
   logic                   any_taken;

   modport requester (output slot_pc, input taken, input target, input any_taken);
   modport responder (input slot_pc, output taken, output target, output any_taken);
endinterface

interface fetch_pkt_if;
   logic                   push;
   fetch_pkg::slot_cnt_t   push_cnt;
   // First slot of the window that carries a valid instruction
   fetch_pkg::slot_cnt_t   push_offset;
   fetch_pkg::insn_t       ins [`FE_FW];
   fetch_pkg::pc_t         pc [`FE_FW];
   fetch_pkg::slot_mask_t  taken;
   // At least FW free entries
   logic                   room;

   modport producer
   (
      output push, output push_cnt, output push_offset,
      output ins, output pc, output taken,
      input  room
   );
   modport consumer
   (
      input  push, input push_cnt, input push_offset,
      input  ins, input pc, input taken,
      output room
   );
endinterface

/* verilog/fetch_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch frontend types
// Address, instruction, slot and BTB vectors,
// fetch FSM state encoding
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "frontend_config.svh"

package fetch_pkg;

   // Word address of one instruction
   typedef logic [`FE_PC_W-1:0]                        pc_t;
   typedef logic [`FE_INSN_DW-1:0]                     insn_t;
   // Byte address aligned to the fetch window
   typedef logic [`FE_AW-1:0]                          win_addr_t;
   typedef logic [`FE_FW-1:0]                          slot_mask_t;
   // Counts 0 to FW instructions
   typedef logic [`FE_P_FW:0]                          slot_cnt_t;
   typedef logic [`FE_P_BTB-1:0]                       btb_idx_t;
   typedef logic [`FE_PC_W-`FE_P_BTB-1:0]              btb_tag_t;
   typedef logic [1:0]                                 bp_cnt_t;
   // Queue pointer, MSB is the wrap bit
   typedef logic [`FE_P_IQ_DEPTH:0]                    iq_ptr_t;

   typedef enum logic [1:0]
   {
      FS_IDLE,
      FS_REQ,
      FS_RELEASE
   } fetch_state_t;

endpackage

/* verilog/fetch_queue.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Prefetch queue toward decode
// Circular buffer with wrap-bit pointers,
// offset push and multi-entry pop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "frontend_config.svh"

module fetch_queue
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   fetch_pkt_if.consumer            pkt,
   output fetch_pkg::slot_mask_t    id_valid,
   output fetch_pkg::insn_t         id_ins [`FE_FW],
   output fetch_pkg::pc_t           id_pc [`FE_FW],
   output fetch_pkg::slot_mask_t    id_bpu_taken,
   input  fetch_pkg::slot_cnt_t     id_pop_cnt
);

   fetch_pkg::insn_t       ins_mem [`FE_IQ_DEPTH];
   fetch_pkg::pc_t         pc_mem [`FE_IQ_DEPTH];
   logic                   tkn_mem [`FE_IQ_DEPTH];

   fetch_pkg::iq_ptr_t     rptr;
   fetch_pkg::iq_ptr_t     wptr;
   fetch_pkg::iq_ptr_t     count;
   fetch_pkg::iq_ptr_t     free_cnt;
   fetch_pkg::iq_ptr_t     wr_ptr [`FE_FW];
   fetch_pkg::iq_ptr_t     rd_ptr [`FE_FW];
   fetch_pkg::slot_cnt_t   wr_src [`FE_FW];
   logic [`FE_FW-1:0]      wr_en;

   assign count    = wptr - rptr;
   assign free_cnt = fetch_pkg::iq_ptr_t'(`FE_IQ_DEPTH) - count;
   assign pkt.room = (free_cnt >= fetch_pkg::iq_ptr_t'(`FE_FW));

   // Entry j takes window slot push_offset + j
   always_comb
   begin
      for (int j = 0; j < `FE_FW; j++)
      begin
         wr_en[j]  = pkt.push & ~flush & (j < int'(pkt.push_cnt));
         wr_ptr[j] = wptr + fetch_pkg::iq_ptr_t'(j);
         wr_src[j] = pkt.push_offset + fetch_pkg::slot_cnt_t'(j);
      end
   end

   always_ff @(posedge clk)
   begin
      for (int j = 0; j < `FE_FW; j++)
      begin
         if (wr_en[j])
         begin
            ins_mem[wr_ptr[j][`FE_P_IQ_DEPTH-1:0]] <= pkt.ins[wr_src[j][`FE_P_FW-1:0]];
            pc_mem[wr_ptr[j][`FE_P_IQ_DEPTH-1:0]]  <= pkt.pc[wr_src[j][`FE_P_FW-1:0]];
            tkn_mem[wr_ptr[j][`FE_P_IQ_DEPTH-1:0]] <= pkt.taken[wr_src[j][`FE_P_FW-1:0]];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rptr <= '0;
         wptr <= '0;
      end
      else if (flush)
      begin
         rptr <= '0;
         wptr <= '0;
      end
      else
      begin
         if (pkt.push)
            wptr <= wptr + fetch_pkg::iq_ptr_t'(pkt.push_cnt);
         rptr <= rptr + fetch_pkg::iq_ptr_t'(id_pop_cnt);
      end
   end

   // Two oldest entries toward decode
   always_comb
   begin
      for (int i = 0; i < `FE_FW; i++)
      begin
         rd_ptr[i]       = rptr + fetch_pkg::iq_ptr_t'(i);
         id_valid[i]     = (count > fetch_pkg::iq_ptr_t'(i));
         id_ins[i]       = ins_mem[rd_ptr[i][`FE_P_IQ_DEPTH-1:0]];
         id_pc[i]        = pc_mem[rd_ptr[i][`FE_P_IQ_DEPTH-1:0]];
         id_bpu_taken[i] = tkn_mem[rd_ptr[i][`FE_P_IQ_DEPTH-1:0]] & id_valid[i];
      end
   end

   // Decode pops only what it was shown
   a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
      int'(id_pop_cnt) <= $countones(id_valid));

endmodule

/* verilog/frontend_config.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch frontend configuration macros
// Address and instruction widths, fetch width,
// prefetch queue depth, BTB size, reset vector
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// Byte address width
`define FE_AW              32
// log2 of instruction bytes
`define FE_P_INSN_LEN      2
// log2 of instructions per fetch window
`define FE_P_FW            1
// log2 of prefetch queue entries
`define FE_P_IQ_DEPTH      3
// log2 of BTB entries
`define FE_P_BTB           4
// Byte address of the first fetch
`define FE_RST_VECTOR      32'h0000_0100

// Derived sizes
`define FE_INSN_DW         (8 << `FE_P_INSN_LEN)
`define FE_PC_W            (`FE_AW - `FE_P_INSN_LEN)
`define FE_FW              (1 << `FE_P_FW)
`define FE_IQ_DEPTH        (1 << `FE_P_IQ_DEPTH)
`define FE_BTB_NUM         (1 << `FE_P_BTB)

`endif

/* verilog/imem_fetch.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction memory read master
// Four-phase req/ack FSM, flush discard,
// packet hand-off to the prefetch queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "frontend_config.svh"

module imem_fetch
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              flush,
   input  fetch_pkg::win_addr_t              fetch_addr,
   input  fetch_pkg::slot_mask_t             slot_valid,
   input  fetch_pkg::pc_t                    slot_pc [`FE_FW],
   input  fetch_pkg::slot_cnt_t              push_cnt,
   input  fetch_pkg::slot_cnt_t              push_offset,
   input  fetch_pkg::slot_mask_t             bpu_taken,
   output logic                              imem_req,
   output fetch_pkg::win_addr_t              imem_addr,
   input  logic                              imem_ack,
   input  logic [`FE_FW*`FE_INSN_DW-1:0]     imem_rdata,
   output logic                              fetch_done,
   fetch_pkt_if.producer                     pkt
);

   fetch_pkg::fetch_state_t   state;
   fetch_pkg::fetch_state_t   state_nxt;
   logic                      discard;
   logic                      req_start;

   // No new fetch in a flush cycle, the PC is not yet retargeted
   always_comb
   begin
      state_nxt = state;
      case (state)
         fetch_pkg::FS_IDLE:
            if (pkt.room && !flush)
               state_nxt = fetch_pkg::FS_REQ;
         fetch_pkg::FS_REQ:
            if (imem_ack)
               state_nxt = fetch_pkg::FS_RELEASE;
         fetch_pkg::FS_RELEASE:
            if (!imem_ack)
               state_nxt = (pkt.room && !flush) ? fetch_pkg::FS_REQ : fetch_pkg::FS_IDLE;
         default:
            state_nxt = fetch_pkg::FS_IDLE;
      endcase
   end

   assign req_start = (state != fetch_pkg::FS_REQ) && (state_nxt == fetch_pkg::FS_REQ);
   assign imem_req  = (state == fetch_pkg::FS_REQ);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= fetch_pkg::FS_IDLE;
         discard <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         // Flush mid-fetch drops the data but keeps the handshake
         if (state == fetch_pkg::FS_REQ)
         begin
            if (imem_ack)
               discard <= 1'b0;
            else if (flush)
               discard <= 1'b1;
         end
      end
   end

   // Held for the whole request
   always_ff @(posedge clk)
   begin
      if (req_start)
         imem_addr <= fetch_addr;
   end

   assign fetch_done = (state == fetch_pkg::FS_REQ) & imem_ack & ~discard & ~flush;

   assign pkt.push        = fetch_done;
   assign pkt.push_cnt    = push_cnt;
   assign pkt.push_offset = push_offset;
   assign pkt.taken       = bpu_taken & slot_valid;

   always_comb
   begin
      for (int i = 0; i < `FE_FW; i++)
      begin
         pkt.ins[i] = imem_rdata[i*`FE_INSN_DW +: `FE_INSN_DW];
         pkt.pc[i]  = slot_pc[i];
      end
   end

   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (state == fetch_pkg::FS_REQ && !imem_ack) |=> imem_req);

endmodule

/* verilog/pc_gen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC register and next-PC selection
// Window alignment, slot valid mask, slot PCs,
// push count and push offset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "frontend_config.svh"

module pc_gen
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  fetch_pkg::pc_t           flush_tgt,
   input  logic                     fetch_done,
   bpu_lookup_if.requester          bpu,
   output fetch_pkg::win_addr_t     fetch_addr,
   output fetch_pkg::slot_mask_t    slot_valid,
   output fetch_pkg::pc_t           slot_pc [`FE_FW],
   output fetch_pkg::slot_cnt_t     push_cnt,
   output fetch_pkg::slot_cnt_t     push_offset
);

   fetch_pkg::pc_t         pc;
   fetch_pkg::pc_t         pc_nxt;
   fetch_pkg::pc_t         win_pc;
   fetch_pkg::pc_t         pred_tgt;
   fetch_pkg::slot_mask_t  aligned;
   fetch_pkg::slot_mask_t  taken_vld;
   logic [`FE_P_FW-1:0]    word_ofs;
   logic                   blocked;

   // Word position of the PC inside its window
   assign word_ofs   = pc[`FE_P_FW-1:0];
   assign win_pc     = {pc[`FE_PC_W-1:`FE_P_FW], {`FE_P_FW{1'b0}}};
   assign fetch_addr = {win_pc, {`FE_P_INSN_LEN{1'b0}}};

   always_comb
   begin
      blocked     = 1'b0;
      push_cnt    = '0;
      push_offset = '0;
      for (int i = 0; i < `FE_FW; i++)
      begin
         slot_pc[i]     = win_pc + fetch_pkg::pc_t'(i);
         bpu.slot_pc[i] = slot_pc[i];
         aligned[i]     = (i >= int'(word_ofs));
         // A taken slot ends the window
         slot_valid[i]  = aligned[i] & ~blocked;
         blocked        = blocked | (slot_valid[i] & bpu.taken[i]);
         push_cnt       = push_cnt + fetch_pkg::slot_cnt_t'(slot_valid[i]);
         push_offset    = push_offset + fetch_pkg::slot_cnt_t'(~aligned[i]);
      end
   end

   assign taken_vld = bpu.taken & slot_valid;

   // Earliest valid taken slot wins
   always_comb
   begin
      pred_tgt = bpu.target[0];
      for (int i = `FE_FW - 1; i >= 0; i--)
      begin
         if (taken_vld[i])
            pred_tgt = bpu.target[i];
      end
   end

   always_comb
   begin
      if (flush)
         pc_nxt = flush_tgt;
      else if (!fetch_done)
         pc_nxt = pc;
      else if (bpu.any_taken && (|taken_vld))
         pc_nxt = pred_tgt;
      else
         pc_nxt = pc + fetch_pkg::pc_t'(push_cnt);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         pc <= fetch_pkg::pc_t'(`FE_RST_VECTOR >> `FE_P_INSN_LEN);
      else
         pc <= pc_nxt;
   end

   // A completed fetch always delivers the instruction at the PC
   a_push_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_done |-> (push_cnt != '0));

endmodule
